// File: hdl/apb_bus_pkg.sv
package apb_bus_pkg;

   // --------------------------------------------------
   // Bus widths
   // --------------------------------------------------
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // Slave 0 is the ALUT, slaves 1 to 4 are the MAC ports
   localparam int SLV_NUM   = 5;
   localparam int SLV_IDX_W = 3;
   localparam int MAC_NUM   = SLV_NUM - 1;

   // --------------------------------------------------
   // Address map
   // --------------------------------------------------
   localparam logic [ADDR_W-1:0] MAP_BASE      = 32'h00A0_0000;
   localparam logic [ADDR_W-1:0] MAP_SLOT_SIZE = 32'h0001_0000;
   // First address past the last slave slot
   localparam logic [ADDR_W-1:0] MAP_END       = MAP_BASE + SLV_NUM * MAP_SLOT_SIZE;
   // Slot number starts at this address bit
   localparam int SLOT_SHIFT = $clog2(MAP_SLOT_SIZE);

   // AHB transfer types
   typedef enum logic [1:0] {
      HTRANS_IDLE   = 2'b00,
      HTRANS_BUSY   = 2'b01,
      HTRANS_NONSEQ = 2'b10,
      HTRANS_SEQ    = 2'b11
   } htrans_e;

   // AHB responses, only OKAY and ERROR used
   typedef enum logic [1:0] {
      HRESP_OKAY  = 2'b00,
      HRESP_ERROR = 2'b01
   } hresp_e;

   // Bridge FSM
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SETUP,
      ST_ACCESS,
      ST_ERR1,
      ST_ERR2
   } bridge_state_e;

endpackage

// File: hdl/alut_pkg.sv
package alut_pkg;

   // --------------------------------------------------
   // Table geometry
   // --------------------------------------------------
   localparam int ALUT_ENTRIES = 8;
   localparam int ALUT_PTR_W   = 3;
   // Count runs 0 to ALUT_ENTRIES
   localparam int ALUT_CNT_W   = 4;
   localparam int PORT_W       = 2;
   localparam int MAC_W        = 48;

   // --------------------------------------------------
   // Register offsets on paddr[6:0]
   // --------------------------------------------------
   localparam int REG_OFF_W = 7;

   // MAC bits 31..0
   localparam logic [REG_OFF_W-1:0] REG_MAC_LO = 7'h00;
   // MAC bits 47..32
   localparam logic [REG_OFF_W-1:0] REG_MAC_HI = 7'h04;
   // Port for LEARN
   localparam logic [REG_OFF_W-1:0] REG_PORT   = 7'h08;
   // Write only
   localparam logic [REG_OFF_W-1:0] REG_CMD    = 7'h0C;
   // Read only
   localparam logic [REG_OFF_W-1:0] REG_STATUS = 7'h10;

   // Status field positions
   localparam int STS_HIT_BIT  = 0;
   localparam int STS_PORT_LSB = 1;
   localparam int STS_CNT_LSB  = 4;

   // Command opcodes, written to REG_CMD[1:0]
   typedef enum logic [1:0] {
      CMD_NOP    = 2'd0,
      CMD_LEARN  = 2'd1,
      CMD_LOOKUP = 2'd2,
      CMD_CLEAR  = 2'd3
   } alut_cmd_e;

   // One table entry
   typedef struct packed {
      logic              valid;
      logic [MAC_W-1:0]  mac;
      logic [PORT_W-1:0] port;
   } alut_entry_t;

endpackage

// File: hdl/apb_if.sv
`timescale 1ns/10ps

interface apb_if;
   import apb_bus_pkg::*;

   // Driven by the bridge
   logic [ADDR_W-1:0]    paddr;
   logic                 pwrite;
   logic                 penable;
   logic [DATA_W-1:0]    pwdata;
   logic [SLV_IDX_W-1:0] psel_idx;
   logic                 psel;

   // Combined response from the mux
   logic [DATA_W-1:0]    prdata;
   logic                 pready;

   // ALUT select and read data
   logic                 psel_alut;
   logic [DATA_W-1:0]    alut_prdata;

   modport bridge (
      output paddr, pwrite, penable, pwdata, psel_idx, psel,
      input  prdata, pready
   );

   modport mux (
      input  psel_idx, psel, alut_prdata,
      output prdata, pready, psel_alut
   );

   modport alut (
      input  paddr, pwrite, penable, pwdata, psel_alut,
      output alut_prdata
   );

endinterface

// File: hdl/ahb_apb_bridge.sv
`timescale 1ns/10ps

module ahb_apb_bridge (
   input  logic                                hclk,
   input  logic                                arst_n,
   // AHB-Lite slave side
   input  logic                                hsel,
   input  logic [apb_bus_pkg::ADDR_W-1:0]      haddr,
   input  apb_bus_pkg::htrans_e                htrans,
   input  logic                                hwrite,
   input  logic [apb_bus_pkg::DATA_W-1:0]      hwdata,
   input  logic                                hready_in,
   output logic [apb_bus_pkg::DATA_W-1:0]      hrdata,
   output logic                                hready,
   output apb_bus_pkg::hresp_e                 hresp,
   // APB master side
   apb_if.bridge                               apb
);
   import apb_bus_pkg::*;

   bridge_state_e        state_q;
   bridge_state_e        state_d;

   logic                 accept;
   logic                 in_win;
   logic [ADDR_W-1:0]    slot_off;
   logic [SLV_IDX_W-1:0] slv_idx;

   // Captured address phase
   logic [ADDR_W-1:0]    addr_q;
   logic                 write_q;
   logic [SLV_IDX_W-1:0] idx_q;
   // hwdata held from SETUP onwards
   logic [DATA_W-1:0]    wdata_q;

   // --------------------------------------------------
   // Address decode
   // --------------------------------------------------
   assign in_win   = (haddr >= MAP_BASE) && (haddr < MAP_END);
   assign slot_off = haddr - MAP_BASE;
   // Slot number above the base
   assign slv_idx  = slot_off[SLOT_SHIFT +: SLV_IDX_W];

   // Valid address phase seen by this slave
   assign accept = hsel && hready_in && hready &&
                   ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

   // --------------------------------------------------
   // AHB response
   // --------------------------------------------------
   always_comb begin
      case (state_q)
         ST_SETUP:  hready = 1'b0;
         // Wait states from the slave
         ST_ACCESS: hready = apb.pready;
         ST_ERR1:   hready = 1'b0;
         default:   hready = 1'b1;
      endcase
   end

   // Two-cycle error on ERR1 and ERR2
   assign hresp = ((state_q == ST_ERR1) || (state_q == ST_ERR2)) ? HRESP_ERROR : HRESP_OKAY;

   // Read data only on the completing cycle
   assign hrdata = (state_q == ST_ACCESS) ? apb.prdata : '0;

   // --------------------------------------------------
   // Bridge FSM
   // --------------------------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_SETUP: state_d = ST_ACCESS;
         ST_ERR1:  state_d = ST_ERR2;
         default: begin
            // IDLE, ERR2 and a finishing ACCESS can take a new transfer
            if (accept) begin
               state_d = in_win ? ST_SETUP : ST_ERR1;
            end else if (hready) begin
               state_d = ST_IDLE;
            end
         end
      endcase
   end

   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= ST_IDLE;
         write_q <= 1'b0;
         idx_q   <= '0;
      end else begin
         state_q <= state_d;
         if (accept) begin
            write_q <= hwrite;
            idx_q   <= slv_idx;
         end
      end
   end

   // Address and data payload
   always_ff @(posedge hclk) begin
      if (accept) begin
         addr_q <= haddr;
      end
      // Data phase of the accepted write
      if (state_q == ST_SETUP) begin
         wdata_q <= hwdata;
      end
   end

   // --------------------------------------------------
   // APB outputs
   // --------------------------------------------------
   assign apb.paddr    = addr_q;
   assign apb.pwrite   = write_q;
   assign apb.psel_idx = idx_q;
   assign apb.psel     = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
   assign apb.penable  = (state_q == ST_ACCESS);
   // hwdata straight through in SETUP, held copy in ACCESS
   assign apb.pwdata   = (state_q == ST_SETUP) ? hwdata : wdata_q;

endmodule

// File: hdl/apb_slave_mux.sv
`timescale 1ns/10ps

module apb_slave_mux (
   apb_if.mux                                                         apb,
   // External MAC register ports
   output logic [apb_bus_pkg::MAC_NUM-1:0]                            psel_mac,
   input  logic [apb_bus_pkg::MAC_NUM-1:0][apb_bus_pkg::DATA_W-1:0]   prdata_mac,
   input  logic [apb_bus_pkg::MAC_NUM-1:0]                            pready_mac
);
   import apb_bus_pkg::*;

   // One-hot select, bit 0 is the ALUT
   logic [SLV_NUM-1:0] psel_vec;

   // --------------------------------------------------
   // Select decode
   // --------------------------------------------------
   always_comb begin
      for (int i = 0; i < SLV_NUM; i++) begin
         psel_vec[i] = apb.psel && (apb.psel_idx == SLV_IDX_W'(i));
      end
   end

   assign apb.psel_alut = psel_vec[0];
   assign psel_mac      = psel_vec[SLV_NUM-1:1];

   // --------------------------------------------------
   // Read data and ready combine
   // --------------------------------------------------
   always_comb begin
      // Unmapped index, never started by the bridge
      apb.prdata = '0;
      apb.pready = 1'b1;
      if (apb.psel_idx == '0) begin
         // ALUT has no wait states
         apb.prdata = apb.alut_prdata;
         apb.pready = 1'b1;
      end
      for (int i = 0; i < MAC_NUM; i++) begin
         // MAC slots sit one above their port number
         if (apb.psel_idx == SLV_IDX_W'(i + 1)) begin
            apb.prdata = prdata_mac[i];
            apb.pready = pready_mac[i];
         end
      end
   end

endmodule

// File: hdl/alut_veneer.sv
`timescale 1ns/10ps

module alut_veneer (
   input  logic hclk,
   input  logic arst_n,
   apb_if.alut  apb
);
   import apb_bus_pkg::*;
   import alut_pkg::*;

   // Staging registers
   logic [DATA_W-1:0]       mac_lo_q;
   logic [MAC_W-DATA_W-1:0] mac_hi_q;
   logic [PORT_W-1:0]       port_q;

   // Table and replace pointer
   alut_entry_t             tbl_q [ALUT_ENTRIES];
   logic [ALUT_PTR_W-1:0]   rr_ptr_q;

   // Lookup status
   logic                    hit_q;
   logic [PORT_W-1:0]       found_port_q;

   logic [REG_OFF_W-1:0]    reg_off;
   logic                    wr_en;
   logic                    cmd_wr;
   alut_cmd_e               cmd;
   logic [MAC_W-1:0]        cur_mac;

   // Search results
   logic                    match_hit;
   logic [ALUT_PTR_W-1:0]   match_idx;
   logic                    free_hit;
   logic [ALUT_PTR_W-1:0]   free_idx;
   logic [ALUT_PTR_W-1:0]   learn_idx;
   logic [ALUT_CNT_W-1:0]   valid_cnt;

   assign reg_off = apb.paddr[REG_OFF_W-1:0];
   // Always ready, so ACCESS lasts one cycle
   assign wr_en   = apb.psel_alut && apb.penable && apb.pwrite;
   assign cmd_wr  = wr_en && (reg_off == REG_CMD);
   assign cmd     = alut_cmd_e'(apb.pwdata[1:0]);
   assign cur_mac = {mac_hi_q, mac_lo_q};

   // --------------------------------------------------
   // Table search
   // --------------------------------------------------
   always_comb begin
      match_hit = 1'b0;
      match_idx = '0;
      free_hit  = 1'b0;
      free_idx  = '0;
      valid_cnt = '0;
      // Walk down so the lowest index wins
      for (int i = ALUT_ENTRIES - 1; i >= 0; i--) begin
         if (tbl_q[i].valid && (tbl_q[i].mac == cur_mac)) begin
            match_hit = 1'b1;
            match_idx = ALUT_PTR_W'(i);
         end
         if (!tbl_q[i].valid) begin
            free_hit = 1'b1;
            free_idx = ALUT_PTR_W'(i);
         end
         valid_cnt = valid_cnt + ALUT_CNT_W'(tbl_q[i].valid);
      end
   end

   // Existing entry, else lowest free, else round robin
   assign learn_idx = match_hit ? match_idx : (free_hit ? free_idx : rr_ptr_q);

   // --------------------------------------------------
   // Registers and command engine
   // --------------------------------------------------
   always_ff @(posedge hclk or negedge arst_n) begin
      if (!arst_n) begin
         mac_lo_q     <= '0;
         mac_hi_q     <= '0;
         port_q       <= '0;
         tbl_q        <= '{default: '0};
         rr_ptr_q     <= '0;
         hit_q        <= 1'b0;
         found_port_q <= '0;
      end else begin
         if (wr_en && (reg_off == REG_MAC_LO)) begin
            mac_lo_q <= apb.pwdata;
         end
         if (wr_en && (reg_off == REG_MAC_HI)) begin
            mac_hi_q <= apb.pwdata[MAC_W-DATA_W-1:0];
         end
         if (wr_en && (reg_off == REG_PORT)) begin
            port_q <= apb.pwdata[PORT_W-1:0];
         end
         if (cmd_wr) begin
            case (cmd)
               CMD_LEARN: begin
                  tbl_q[learn_idx] <= '{valid: 1'b1, mac: cur_mac, port: port_q};
                  // Pointer moves only on a replacement
                  if (!match_hit && !free_hit) begin
                     rr_ptr_q <= rr_ptr_q + 1'b1;
                  end
               end
               CMD_LOOKUP: begin
                  hit_q        <= match_hit;
                  found_port_q <= match_hit ? tbl_q[match_idx].port : '0;
               end
               CMD_CLEAR: begin
                  for (int i = 0; i < ALUT_ENTRIES; i++) begin
                     tbl_q[i].valid <= 1'b0;
                  end
                  rr_ptr_q <= '0;
               end
               default: ;
            endcase
         end
      end
   end

   // --------------------------------------------------
   // Read path
   // --------------------------------------------------
   always_comb begin
      apb.alut_prdata = '0;
      case (reg_off)
         REG_MAC_LO: apb.alut_prdata = mac_lo_q;
         REG_MAC_HI: apb.alut_prdata[MAC_W-DATA_W-1:0] = mac_hi_q;
         REG_PORT:   apb.alut_prdata[PORT_W-1:0] = port_q;
         REG_STATUS: begin
            apb.alut_prdata[STS_HIT_BIT]                 = hit_q;
            apb.alut_prdata[STS_PORT_LSB +: PORT_W]      = found_port_q;
            apb.alut_prdata[STS_CNT_LSB +: ALUT_CNT_W]   = valid_cnt;
         end
         // REG_CMD and holes read zero
         default: apb.alut_prdata = '0;
      endcase
   end

endmodule

// File: hdl/apb_subsystem.sv
`timescale 1ns/10ps

module apb_subsystem (
   input  logic                               hclk,
   input  logic                               arst_n,
   // AHB-Lite slave port
   input  logic                               hsel,
   input  logic [apb_bus_pkg::ADDR_W-1:0]     haddr,
   input  apb_bus_pkg::htrans_e               htrans,
   input  logic                               hwrite,
   input  logic [apb_bus_pkg::DATA_W-1:0]     hwdata,
   input  logic                               hready_in,
   output logic [apb_bus_pkg::DATA_W-1:0]     hrdata,
   output logic                               hready,
   output apb_bus_pkg::hresp_e                hresp,
   // Shared APB signals to the MACs
   output logic [apb_bus_pkg::ADDR_W-1:0]     paddr,
   output logic                               pwrite,
   output logic                               penable,
   output logic [apb_bus_pkg::DATA_W-1:0]     pwdata,
   // MAC0 to MAC3 slave ports
   output logic                               psel_mac0,
   output logic                               psel_mac1,
   output logic                               psel_mac2,
   output logic                               psel_mac3,
   input  logic [apb_bus_pkg::DATA_W-1:0]     prdata_mac0,
   input  logic [apb_bus_pkg::DATA_W-1:0]     prdata_mac1,
   input  logic [apb_bus_pkg::DATA_W-1:0]     prdata_mac2,
   input  logic [apb_bus_pkg::DATA_W-1:0]     prdata_mac3,
   input  logic                               pready_mac0,
   input  logic                               pready_mac1,
   input  logic                               pready_mac2,
   input  logic                               pready_mac3
);
   import apb_bus_pkg::*;

   apb_if apb ();

   // MAC ports gathered for the mux, index 0 is MAC0
   logic [MAC_NUM-1:0]             psel_mac;
   logic [MAC_NUM-1:0][DATA_W-1:0] prdata_mac;
   logic [MAC_NUM-1:0]             pready_mac;

   assign prdata_mac = {prdata_mac3, prdata_mac2, prdata_mac1, prdata_mac0};
   assign pready_mac = {pready_mac3, pready_mac2, pready_mac1, pready_mac0};
   assign {psel_mac3, psel_mac2, psel_mac1, psel_mac0} = psel_mac;

   // Shared APB outputs
   assign paddr   = apb.paddr;
   assign pwrite  = apb.pwrite;
   assign penable = apb.penable;
   assign pwdata  = apb.pwdata;

   ahb_apb_bridge u_bridge (
      .hclk      (hclk),
      .arst_n    (arst_n),
      .hsel      (hsel),
      .haddr     (haddr),
      .htrans    (htrans),
      .hwrite    (hwrite),
      .hwdata    (hwdata),
      .hready_in (hready_in),
      .hrdata    (hrdata),
      .hready    (hready),
      .hresp     (hresp),
      .apb       (apb.bridge)
   );

   apb_slave_mux u_mux (
      .apb        (apb.mux),
      .psel_mac   (psel_mac),
      .prdata_mac (prdata_mac),
      .pready_mac (pready_mac)
   );

   // Internal lookup table on slot 0
   alut_veneer u_alut (
      .hclk   (hclk),
      .arst_n (arst_n),
      .apb    (apb.alut)
   );

endmodule

// File: verif/tb_apb_subsystem.sv
`timescale 1ns/10ps

module tb_apb_subsystem;
   import apb_bus_pkg::*;
   import alut_pkg::*;

   localparam int          XFER_TIMEOUT = 32;
   localparam logic [31:0] ALUT_BASE    = MAP_BASE;

   // DUT ports
   logic        hclk = 1'b0;
   logic        arst_n;
   logic        hsel;
   logic [31:0] haddr;
   htrans_e     htrans;
   logic        hwrite;
   logic [31:0] hwdata;
   logic        hready_in;
   logic [31:0] hrdata;
   logic        hready;
   hresp_e      hresp;
   logic [31:0] paddr;
   logic        pwrite;
   logic        penable;
   logic [31:0] pwdata;
   logic [3:0]  psel_vec;
   logic [31:0] prdata_mac [4] = '{default: '0};
   logic [3:0]  pready_mac = '0;

   // MAC slave models
   logic [31:0] mac_mem [4][16];
   int          wait_left [4];
   int          last_wait [4];
   // Select the running transfer may raise
   logic [3:0]  exp_sel = '0;
   // Payload the running transfer must put on the APB bus
   logic [31:0] exp_addr  = '0;
   logic        exp_write = 1'b0;
   logic [31:0] exp_wdata = '0;

   // Result of the last AHB transfer
   logic [31:0] last_rdata;
   int          last_lat;
   hresp_e      last_resp1;
   hresp_e      last_resp;

   // ALUT reference model
   logic        m_valid [8];
   logic [47:0] m_mac [8];
   logic [1:0]  m_port [8];
   logic [2:0]  m_ptr;
   logic        m_hit;
   logic [1:0]  m_fport;

   always #20 hclk = ~hclk;

   apb_subsystem u_dut (
      .hclk        (hclk),
      .arst_n      (arst_n),
      .hsel        (hsel),
      .haddr       (haddr),
      .htrans      (htrans),
      .hwrite      (hwrite),
      .hwdata      (hwdata),
      .hready_in   (hready_in),
      .hrdata      (hrdata),
      .hready      (hready),
      .hresp       (hresp),
      .paddr       (paddr),
      .pwrite      (pwrite),
      .penable     (penable),
      .pwdata      (pwdata),
      .psel_mac0   (psel_vec[0]),
      .psel_mac1   (psel_vec[1]),
      .psel_mac2   (psel_vec[2]),
      .psel_mac3   (psel_vec[3]),
      .prdata_mac0 (prdata_mac[0]),
      .prdata_mac1 (prdata_mac[1]),
      .prdata_mac2 (prdata_mac[2]),
      .prdata_mac3 (prdata_mac[3]),
      .pready_mac0 (pready_mac[0]),
      .pready_mac1 (pready_mac[1]),
      .pready_mac2 (pready_mac[2]),
      .pready_mac3 (pready_mac[3])
   );

   // --------------------------------------------------
   // Failure reporting
   // --------------------------------------------------
   task automatic abort_run(input string line);
      $display("%s", line);
      $display("TESTS FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      abort_run($sformatf("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act));
   endtask

   task automatic expect_equal(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      assert (act === exp) else report_mismatch(name, exp, act);
   endtask

   // --------------------------------------------------
   // Protocol checks
   // --------------------------------------------------
   // Quiet bus while in reset
   assert property (@(posedge hclk) !arst_n |->
                    (psel_vec == '0 && !penable && hready && hresp == HRESP_OKAY))
      else abort_run("Bus not idle or response not OKAY during reset");
   assert property (@(posedge hclk) disable iff (!arst_n) (|psel_vec && !penable) |=> penable)
      else abort_run("penable did not follow psel by one cycle");
   // Payload frozen while the slave stalls
   assert property (@(posedge hclk) disable iff (!arst_n) (penable && !hready) |=>
                    (penable && $stable(paddr) && $stable(pwdata) && $stable(pwrite)))
      else abort_run("APB payload or penable changed while waiting for pready");
   assert property (@(posedge hclk) $onehot0(psel_vec))
      else abort_run("More than one MAC select high at once");
   assert property (@(posedge hclk) disable iff (!arst_n)
                    (penable && |(psel_vec & ~pready_mac)) |-> !hready)
      else abort_run("hready high before the selected MAC gave pready");
   assert property (@(posedge hclk) disable iff (!arst_n)
                    (hresp == HRESP_ERROR) |-> (psel_vec == '0 && !penable))
      else abort_run("APB transfer started for a bad address");
   // ERROR with hready low, then ERROR with hready high
   assert property (@(posedge hclk) disable iff (!arst_n)
                    (hresp == HRESP_ERROR && !hready) |=> (hresp == HRESP_ERROR && hready))
      else abort_run("Error response was not the two-cycle sequence");

   // --------------------------------------------------
   // MAC slave models with 0 to 3 random wait states
   // --------------------------------------------------
   always @(posedge hclk) begin
      if (psel_vec != '0) begin
         assert (psel_vec == exp_sel) else report_mismatch("psel target", 32'(exp_sel),
                                                           32'(psel_vec));
      end
      // Shared APB payload during ACCESS
      if (penable) begin
         expect_equal("APB address", exp_addr, paddr);
         expect_equal("APB direction", 32'(exp_write), 32'(pwrite));
         if (exp_write) begin
            expect_equal("APB write data", exp_wdata, pwdata);
         end
      end
      for (int m = 0; m < 4; m++) begin
         if (!arst_n) begin
            pready_mac[m] <= 1'b0;
            wait_left[m] = 0;
            for (int w = 0; w < 16; w++) begin
               mac_mem[m][w] <= 32'hC0DE_0000 | 32'(m * 256 + w);
            end
         end else if (psel_vec[m] && !penable) begin
            // End of SETUP
            wait_left[m] = $urandom_range(3, 0);
            last_wait[m] = wait_left[m];
            pready_mac[m] <= (wait_left[m] == 0);
            prdata_mac[m] <= mac_mem[m][paddr[5:2]];
         end else if (psel_vec[m] && penable) begin
            if (pready_mac[m]) begin
               if (pwrite) begin
                  mac_mem[m][paddr[5:2]] <= pwdata;
               end
               pready_mac[m] <= 1'b0;
            end else begin
               wait_left[m] = wait_left[m] - 1;
               pready_mac[m] <= (wait_left[m] == 0);
            end
         end
      end
   end

   // --------------------------------------------------
   // AHB master tasks
   // --------------------------------------------------
   task automatic ahb_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] sel);
      int cyc;
      @(posedge hclk);
      hsel      <= 1'b1;
      haddr     <= addr;
      htrans    <= HTRANS_NONSEQ;
      hwrite    <= wr;
      exp_sel   <= sel;
      exp_addr  <= addr;
      exp_write <= wr;
      exp_wdata <= wdata;
      // Bridge takes the address phase on this edge
      @(posedge hclk);
      hsel   <= 1'b0;
      htrans <= HTRANS_IDLE;
      hwdata <= wdata;
      cyc = 0;
      last_resp1 = HRESP_OKAY;
      do begin
         @(negedge hclk);
         cyc++;
         if (cyc == 1) begin
            last_resp1 = hresp;
         end
         if (cyc > XFER_TIMEOUT) begin
            abort_run($sformatf("Timeout waiting for hready at address 0x%08h", addr));
         end
      end while (!hready);
      last_lat   = cyc;
      last_rdata = hrdata;
      last_resp  = hresp;
   endtask

   task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] sel);
      ahb_xfer(1'b1, addr, data, sel);
      expect_equal("write response", 32'(HRESP_OKAY), 32'(last_resp));
   endtask

   task automatic ahb_read(input logic [31:0] addr, input logic [3:0] sel);
      ahb_xfer(1'b0, addr, 32'h0, sel);
      expect_equal("read response", 32'(HRESP_OKAY), 32'(last_resp));
   endtask

   task automatic error_xfer(input string name, input logic wr, input logic [31:0] addr);
      ahb_xfer(wr, addr, $urandom(), 4'b0000);
      expect_equal({name, " first cycle"}, 32'(HRESP_ERROR), 32'(last_resp1));
      expect_equal({name, " second cycle"}, 32'(HRESP_ERROR), 32'(last_resp));
      expect_equal({name, " length"}, 32'd2, 32'(last_lat));
   endtask

   // --------------------------------------------------
   // ALUT reference model
   // --------------------------------------------------
   function automatic int model_find(input logic [47:0] mac);
      int idx;
      idx = -1;
      // Downward walk leaves the lowest match
      for (int i = 7; i >= 0; i--) begin
         if (m_valid[i] && m_mac[i] == mac) begin
            idx = i;
         end
      end
      return idx;
   endfunction

   task automatic model_learn(input logic [47:0] mac, input logic [1:0] port);
      int idx;
      int free;
      idx  = model_find(mac);
      free = -1;
      for (int i = 7; i >= 0; i--) begin
         if (!m_valid[i]) begin
            free = i;
         end
      end
      if (idx < 0) begin
         idx = free;
      end
      // Full table replaces at the pointer
      if (idx < 0) begin
         idx   = int'(m_ptr);
         m_ptr = m_ptr + 3'd1;
      end
      m_valid[idx] = 1'b1;
      m_mac[idx]   = mac;
      m_port[idx]  = port;
   endtask

   task automatic model_lookup(input logic [47:0] mac);
      int idx;
      idx     = model_find(mac);
      m_hit   = (idx >= 0);
      m_fport = (idx >= 0) ? m_port[idx] : 2'd0;
   endtask

   task automatic model_clear();
      for (int i = 0; i < 8; i++) begin
         m_valid[i] = 1'b0;
      end
      m_ptr = 3'd0;
   endtask

   function automatic logic [31:0] model_status();
      int cnt;
      cnt = 0;
      for (int i = 0; i < 8; i++) begin
         cnt += int'(m_valid[i]);
      end
      // Count 7..4, port 2..1, hit 0
      return {24'h0, 4'(cnt), 1'b0, m_fport, m_hit};
   endfunction

   // --------------------------------------------------
   // ALUT register sequences
   // --------------------------------------------------
   task automatic alut_command(input logic [47:0] mac, input alut_cmd_e cmd);
      ahb_write(ALUT_BASE + 32'(REG_MAC_LO), mac[31:0], 4'b0000);
      ahb_write(ALUT_BASE + 32'(REG_MAC_HI), {16'h0000, mac[47:32]}, 4'b0000);
      ahb_write(ALUT_BASE + 32'(REG_CMD), 32'(cmd), 4'b0000);
   endtask

   task automatic learn_mac(input logic [47:0] mac, input logic [1:0] port);
      ahb_write(ALUT_BASE + 32'(REG_PORT), 32'(port), 4'b0000);
      alut_command(mac, CMD_LEARN);
      model_learn(mac, port);
   endtask

   task automatic lookup_mac(input string name, input logic [47:0] mac);
      alut_command(mac, CMD_LOOKUP);
      model_lookup(mac);
      ahb_read(ALUT_BASE + 32'(REG_STATUS), 4'b0000);
      expect_equal(name, model_status(), last_rdata);
      // ALUT never stalls
      expect_equal("ALUT read latency", 32'd2, 32'(last_lat));
   endtask

   task automatic check_alut_read(input string name, input logic [31:0] offset,
                                  input logic [31:0] exp);
      ahb_read(ALUT_BASE + offset, 4'b0000);
      expect_equal(name, exp, last_rdata);
   endtask

   task automatic clear_table();
      alut_command(48'h0, CMD_CLEAR);
      model_clear();
   endtask

   // --------------------------------------------------
   // Stimulus
   // --------------------------------------------------
   initial begin
      logic [31:0] addr;
      logic [31:0] data;
      logic [47:0] macs [9];
      logic [1:0]  ports [5];
      logic [1:0]  new_port;
      logic [47:0] stranger;
      void'($urandom(32'h711cd1fb));
      arst_n    = 1'b0;
      hsel      = 1'b0;
      haddr     = 32'h0;
      htrans    = HTRANS_IDLE;
      hwrite    = 1'b0;
      hwdata    = 32'h0;
      hready_in = 1'b1;
      m_hit     = 1'b0;
      m_fport   = 2'd0;
      model_clear();
      repeat (16) @(posedge hclk);
      arst_n <= 1'b1;

      // Random word and data in each MAC slot
      for (int m = 0; m < 4; m++) begin
         for (int k = 0; k < 3; k++) begin
            addr = MAP_BASE + (m + 1) * MAP_SLOT_SIZE + 32'(4 * $urandom_range(15, 0));
            data = $urandom();
            ahb_write(addr, data, 4'(1 << m));
            expect_equal("MAC write latency", 32'(2 + last_wait[m]), 32'(last_lat));
            ahb_read(addr, 4'(1 << m));
            expect_equal("MAC read data", data, last_rdata);
            expect_equal("MAC read latency", 32'(2 + last_wait[m]), 32'(last_lat));
         end
      end

      // Addresses outside the window
      error_xfer("error above window", 1'b1, 32'h00A5_0000);
      error_xfer("error at zero", 1'b0, 32'h0000_0000);

      // Learn and lookup
      for (int i = 0; i < 5; i++) begin
         macs[i]  = {16'($urandom()), 32'($urandom())};
         ports[i] = 2'($urandom());
         learn_mac(macs[i], ports[i]);
      end
      for (int i = 0; i < 5; i++) begin
         lookup_mac("lookup learned MAC", macs[i]);
      end
      stranger = {16'hFEED, 32'($urandom())};
      lookup_mac("lookup unknown MAC", stranger);
      // Relearn with a new port at the same count
      new_port = ports[2] + 2'd1;
      learn_mac(macs[2], new_port);
      lookup_mac("lookup relearned MAC", macs[2]);

      // Staging registers hold the last writes
      check_alut_read("MAC_LO readback", 32'(REG_MAC_LO), macs[2][31:0]);
      check_alut_read("MAC_HI readback", 32'(REG_MAC_HI), {16'h0000, macs[2][47:32]});
      check_alut_read("PORT readback", 32'(REG_PORT), 32'(new_port));
      // Write-only and unmapped offsets read zero
      check_alut_read("CMD readback", 32'(REG_CMD), 32'h0);
      check_alut_read("unmapped offset readback", 32'h14, 32'h0);

      // Nine distinct MACs wrap the table
      clear_table();
      for (int i = 0; i < 9; i++) begin
         macs[i] = {16'(16'h0200 + i), 32'($urandom())};
         learn_mac(macs[i], 2'(i));
      end
      lookup_mac("lookup replaced MAC", macs[0]);
      expect_equal("full table first MAC hit", 32'h0, 32'(last_rdata[STS_HIT_BIT]));
      for (int i = 1; i < 9; i++) begin
         lookup_mac("lookup full table", macs[i]);
      end
      clear_table();
      for (int i = 0; i < 9; i++) begin
         lookup_mac("lookup after clear", macs[i]);
      end

      $display("TESTS PASSED");
      $finish;
   end

endmodule

// File: project.f
hdl/apb_bus_pkg.sv
hdl/alut_pkg.sv
hdl/apb_if.sv
hdl/ahb_apb_bridge.sv
hdl/apb_slave_mux.sv
hdl/alut_veneer.sv
hdl/apb_subsystem.sv
verif/tb_apb_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and pass only when the pass line appears
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_apb_subsystem -f project.f \
   && ./obj_dir/Vtb_apb_subsystem | tee /dev/stderr | grep -qx "TESTS PASSED" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

exit 0
